/* src.f */
+incdir+source
+incdir+bench
source/image_pkg.sv
source/hough_pkg.sv
source/fifo.sv
source/bram.sv
source/hysteresis_loader.sv
source/hough_config.sv
source/hough.sv
source/hough_top.sv
bench/hough_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the Hough lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module hough_tb -o hough_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/hough_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
    exit $sim_status
fi

exit 0

/* bench/lane_model.svh */
// Reference vote table and expected lane results for one hysteresis image
`ifndef LANE_MODEL_SVH
`define LANE_MODEL_SVH

// Expected lane outputs of the last modeled frame
rho_t       exp_left_rho;
rho_t       exp_right_rho;
theta_deg_t exp_left_theta;
theta_deg_t exp_right_theta;
logic       exp_left_valid;
logic       exp_right_valid;

// Round half away from zero
function automatic int round_trig(input real v);
    if (v >= 0.0)
        return $rtoi(v + 0.5);
    else
        return -$rtoi(-v + 0.5);
endfunction

// Bin of one pixel at one theta, trig taken from the math library
function automatic int rho_bin_of(input int x, input int y, input int t);
    real ang;
    int  c;
    int  s;
    int  r;
    ang = (20.0 + 10.0 * t) * 3.14159265358979 / 180.0;
    c = round_trig(256.0 * $cos(ang));
    s = round_trig(256.0 * $sin(ang));
    r = (x * c + y * s) >>> 8;
    return r + `RHO_OFFSET;
endfunction

task automatic expect_lanes(input pixel_t img [`IMG_PIXELS], input vote_t thr);
    int votes [`NUM_THETAS][`RHO_BINS];
    int b;
    int lmax;
    int rmax;
    int lt;
    int lb;
    int rt;
    int rb;
    for (int t = 0; t < `NUM_THETAS; t++)
        for (int k = 0; k < `RHO_BINS; k++)
            votes[t][k] = 0;
    for (int p = 0; p < `IMG_PIXELS; p++) begin
        if (img[p][7:0] != 8'h00) begin
            for (int t = 0; t < `NUM_THETAS; t++) begin
                b = rho_bin_of(p % `IMG_WIDTH, p / `IMG_WIDTH, t);
                if (votes[t][b] < 255)
                    votes[t][b]++;
            end
        end
    end
    // Theta outer, bin inner, first strict maximum wins
    lmax = 0;
    rmax = 0;
    lt = 0;
    lb = 0;
    rt = `HALF_THETAS;
    rb = 0;
    for (int t = 0; t < `NUM_THETAS; t++) begin
        for (int k = 0; k < `RHO_BINS; k++) begin
            if (t < `HALF_THETAS && votes[t][k] > lmax) begin
                lmax = votes[t][k];
                lt = t;
                lb = k;
            end else if (t >= `HALF_THETAS && votes[t][k] > rmax) begin
                rmax = votes[t][k];
                rt = t;
                rb = k;
            end
        end
    end
    exp_left_valid  = (lmax >= int'(thr));
    exp_right_valid = (rmax >= int'(thr));
    exp_left_rho    = exp_left_valid ? rho_t'(lb - `RHO_OFFSET) : '0;
    exp_right_rho   = exp_right_valid ? rho_t'(rb - `RHO_OFFSET) : '0;
    exp_left_theta  = exp_left_valid ? theta_deg_t'(20 + 10 * lt) : '0;
    exp_right_theta = exp_right_valid ? theta_deg_t'(20 + 10 * rt) : '0;
endtask

`endif

/* bench/hough_tb.sv */
// Directed-test testbench for the lane-detection Hough top level
`timescale 1ns/100ps
`include "hough_defs.svh"

module hough_tb import image_pkg::*, hough_pkg::*; ();

// Seven frames in total, each bounded by clear, scan and a generous edge count
localparam int NUM_FRAMES = 7;
localparam int MAX_EDGES = 128;
localparam int FRAME_CYCLES = 6000 + 17 * MAX_EDGES;
localparam int WATCHDOG_NS = 2 * NUM_FRAMES * FRAME_CYCLES * 4;

logic       clock = 1'b0;
logic       reset;
logic       hysteresis_wr_en;
pixel_t     hysteresis_din;
logic       hysteresis_full;
logic       cfg_wr_en;
vote_t      cfg_threshold;
rho_t       left_rho;
rho_t       right_rho;
theta_deg_t left_theta;
theta_deg_t right_theta;
logic       left_valid;
logic       right_valid;
logic       hough_done;
logic       busy;

pixel_t      frame_a [`IMG_PIXELS];
pixel_t      frame_b [`IMG_PIXELS];
logic [15:0] lfsr;
logic        full_seen;
vote_t       cur_thr;

`include "lane_model.svh"

hough_top i_dut (
    .clock(clock),
    .reset(reset),
    .hysteresis_wr_en(hysteresis_wr_en),
    .hysteresis_din(hysteresis_din),
    .hysteresis_full(hysteresis_full),
    .cfg_wr_en(cfg_wr_en),
    .cfg_threshold(cfg_threshold),
    .left_rho(left_rho),
    .right_rho(right_rho),
    .left_theta(left_theta),
    .right_theta(right_theta),
    .left_valid(left_valid),
    .right_valid(right_valid),
    .hough_done(hough_done),
    .busy(busy)
);

always #2 clock = ~clock;

task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped");
endtask

initial begin
    #(WATCHDOG_NS);
    abort_run("Timeout, the engine never finished all frames");
end

// Inputs change and outputs are sampled half a nanosecond after each edge
task automatic step();
    @(posedge clock);
    #0.5;
endtask

task automatic check_rho(input string name, input rho_t got, input rho_t want);
    if (got !== want)
        abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
endtask

task automatic check_theta(input string name, input theta_deg_t got, input theta_deg_t want);
    if (got !== want)
        abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want)
        abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, want));
endtask

task automatic check_lanes();
    check_bit("left_valid", left_valid, exp_left_valid);
    check_bit("right_valid", right_valid, exp_right_valid);
    check_rho("left_rho", left_rho, exp_left_rho);
    check_rho("right_rho", right_rho, exp_right_rho);
    check_theta("left_theta", left_theta, exp_left_theta);
    check_theta("right_theta", right_theta, exp_right_theta);
endtask

// Galois LFSR, one step per bit
function automatic logic take_bit();
    logic b;
    b = lfsr[0];
    lfsr = b ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    return b;
endfunction

task automatic send_frame(input pixel_t img [`IMG_PIXELS]);
    int i;
    i = 0;
    while (i < `IMG_PIXELS) begin
        if (hysteresis_full) begin
            hysteresis_wr_en = 1'b0;
            full_seen = 1'b1;
        end else begin
            hysteresis_wr_en = 1'b1;
            hysteresis_din = img[i];
            i++;
        end
        step();
    end
    hysteresis_wr_en = 1'b0;
endtask

task automatic wait_done();
    do
        step();
    while (!hough_done);
endtask

task automatic write_threshold(input vote_t v);
    cfg_wr_en = 1'b1;
    cfg_threshold = v;
    step();
    cfg_wr_en = 1'b0;
endtask

// Background carries the address in the upper bits, low byte zero
task automatic clear_frames();
    for (int p = 0; p < `IMG_PIXELS; p++) begin
        frame_a[p] = {7'h00, image_addr_t'(p), 8'h00};
        frame_b[p] = {7'h00, image_addr_t'(p), 8'h00};
    end
endtask

// Two-pixel-wide diagonals, x+y in {20,21} and x-y in {8,9}
task automatic draw_lines();
    int x;
    clear_frames();
    for (int y = 0; y < `IMG_HEIGHT; y++) begin
        for (int w = 0; w < 2; w++) begin
            x = 20 + w - y;
            frame_a[y * `IMG_WIDTH + x] = {7'h00, image_addr_t'(y * `IMG_WIDTH + x), 8'hc3};
            x = 8 + w + y;
            frame_a[y * `IMG_WIDTH + x] = {7'h00, image_addr_t'(y * `IMG_WIDTH + x), 8'h01};
        end
    end
endtask

// Edge where three taken bits are all one
task automatic draw_random();
    logic b0;
    logic b1;
    logic b2;
    for (int p = 0; p < `IMG_PIXELS; p++) begin
        b0 = take_bit();
        b1 = take_bit();
        b2 = take_bit();
        if (b0 & b1 & b2)
            frame_b[p] = {7'h00, image_addr_t'(p), 8'h80};
    end
endtask

task automatic reset_outputs_low();
    check_bit("hough_done", hough_done, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_bit("left_valid", left_valid, 1'b0);
    check_bit("right_valid", right_valid, 1'b0);
    check_bit("hysteresis_full", hysteresis_full, 1'b0);
endtask

task automatic empty_frame();
    clear_frames();
    expect_lanes(frame_a, cur_thr);
    send_frame(frame_a);
    wait_done();
    check_lanes();
endtask

task automatic lane_pair();
    draw_lines();
    expect_lanes(frame_a, cur_thr);
    send_frame(frame_a);
    wait_done();
    check_lanes();
endtask

task automatic threshold_lock();
    write_threshold(8'd40);
    cur_thr = 8'd40;
    draw_lines();
    expect_lanes(frame_a, cur_thr);
    send_frame(frame_a);
    while (!busy)
        step();
    // Dropped while the engine runs
    write_threshold(8'd1);
    wait_done();
    check_lanes();
    send_frame(frame_a);
    wait_done();
    check_lanes();
    write_threshold(vote_t'(`DEFAULT_THRESHOLD));
    cur_thr = vote_t'(`DEFAULT_THRESHOLD);
endtask

task automatic back_to_back();
    draw_lines();
    draw_random();
    full_seen = 1'b0;
    expect_lanes(frame_a, cur_thr);
    fork
        begin
            send_frame(frame_a);
            send_frame(frame_b);
        end
        begin
            wait_done();
            check_lanes();
            expect_lanes(frame_b, cur_thr);
            wait_done();
            check_lanes();
        end
    join
    check_bit("hysteresis_full seen", full_seen, 1'b1);
endtask

task automatic random_frame();
    write_threshold(8'd4);
    cur_thr = 8'd4;
    clear_frames();
    draw_random();
    expect_lanes(frame_b, cur_thr);
    send_frame(frame_b);
    wait_done();
    check_lanes();
endtask

initial begin
    reset = 1'b1;
    hysteresis_wr_en = 1'b0;
    hysteresis_din = '0;
    cfg_wr_en = 1'b0;
    cfg_threshold = '0;
    lfsr = 16'd23;
    full_seen = 1'b0;
    cur_thr = vote_t'(`DEFAULT_THRESHOLD);
    repeat (16) @(posedge clock);
    #0.5;
    reset = 1'b0;
    reset_outputs_low();
    empty_frame();
    lane_pair();
    threshold_lock();
    back_to_back();
    random_frame();
    $display("RESULT: PASS");
    $finish;
end

endmodule

/* source/hough_top.sv */
// Lane detection top level with pixel FIFO, loader, image and accumulator BRAMs, config and Hough engine
`timescale 1ns/100ps
`include "hough_defs.svh"

module hough_top import image_pkg::*, hough_pkg::*; (
    input  logic        clock,
    input  logic        reset,

    // Hysteresis pixel input
    input  logic        hysteresis_wr_en,
    input  pixel_t      hysteresis_din,
    output logic        hysteresis_full,

    // Threshold configuration
    input  logic        cfg_wr_en,
    input  vote_t       cfg_threshold,

    // Lane results
    output rho_t        left_rho,
    output rho_t        right_rho,
    output theta_deg_t  left_theta,
    output theta_deg_t  right_theta,
    output logic        left_valid,
    output logic        right_valid,
    output logic        hough_done,
    output logic        busy
);

// FIFO to loader
pixel_t         hysteresis_dout;
logic           hysteresis_empty;
logic           hysteresis_rd_en;

// Image BRAM
logic           image_wr_en;
image_addr_t    image_wr_addr;
logic           image_wr_data;
image_addr_t    image_rd_addr;
logic           image_rd_data;

// Accumulator BRAM
logic           accum_wr_en;
accum_addr_t    accum_wr_addr;
vote_t          accum_wr_data;
accum_addr_t    accum_rd_addr;
vote_t          accum_rd_data;

logic           hough_start;
vote_t          threshold;

fifo fifo_hysteresis_inst (
    .clock(clock),
    .reset(reset),
    .wr_en(hysteresis_wr_en),
    .din(hysteresis_din),
    .full(hysteresis_full),
    .rd_en(hysteresis_rd_en),
    .dout(hysteresis_dout),
    .empty(hysteresis_empty)
);

hysteresis_loader hysteresis_loader_inst (
    .clock(clock),
    .reset(reset),
    .in_empty(hysteresis_empty),
    .in_dout(hysteresis_dout),
    .in_rd_en(hysteresis_rd_en),
    .busy(busy),
    .bram_wr_en(image_wr_en),
    .bram_wr_addr(image_wr_addr),
    .bram_wr_data(image_wr_data),
    .hough_start(hough_start)
);

bram #(
    .DATA_WIDTH(1),
    .DEPTH(`IMG_PIXELS)
) image_bram_inst (
    .clock(clock),
    .wr_en(image_wr_en),
    .wr_addr(image_wr_addr),
    .wr_data(image_wr_data),
    .rd_addr(image_rd_addr),
    .rd_data(image_rd_data)
);

bram #(
    .DATA_WIDTH($bits(vote_t)),
    .DEPTH(`NUM_THETAS * `RHO_BINS)
) accum_bram_inst (
    .clock(clock),
    .wr_en(accum_wr_en),
    .wr_addr(accum_wr_addr),
    .wr_data(accum_wr_data),
    .rd_addr(accum_rd_addr),
    .rd_data(accum_rd_data)
);

hough_config hough_config_inst (
    .clock(clock),
    .reset(reset),
    .cfg_wr_en(cfg_wr_en),
    .cfg_threshold(cfg_threshold),
    .busy(busy),
    .threshold(threshold)
);

hough hough_inst (
    .clock(clock),
    .reset(reset),
    .start(hough_start),
    .threshold(threshold),
    .image_rd_addr(image_rd_addr),
    .image_rd_data(image_rd_data),
    .accum_wr_en(accum_wr_en),
    .accum_wr_addr(accum_wr_addr),
    .accum_wr_data(accum_wr_data),
    .accum_rd_addr(accum_rd_addr),
    .accum_rd_data(accum_rd_data),
    .busy(busy),
    .hough_done(hough_done),
    .left_rho(left_rho),
    .right_rho(right_rho),
    .left_theta(left_theta),
    .right_theta(right_theta),
    .left_valid(left_valid),
    .right_valid(right_valid)
);

endmodule

/* source/hough.sv */
// Hough engine with accumulator clear, theta sweep voting, two-half peak scan and lane report
`timescale 1ns/100ps
`include "hough_defs.svh"

module hough import image_pkg::*, hough_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  vote_t       threshold,
    output image_addr_t image_rd_addr,
    input  logic        image_rd_data,
    output logic        accum_wr_en,
    output accum_addr_t accum_wr_addr,
    output vote_t       accum_wr_data,
    output accum_addr_t accum_rd_addr,
    input  vote_t       accum_rd_data,
    output logic        busy,
    output logic        hough_done,
    output rho_t        left_rho,
    output rho_t        right_rho,
    output theta_deg_t  left_theta,
    output theta_deg_t  right_theta,
    output logic        left_valid,
    output logic        right_valid
);

localparam int ACCUM_ENTRIES = `NUM_THETAS * `RHO_BINS;
localparam int BIN_BITS = $bits(rho_bin_t);
localparam int ADDR_BITS = $bits(accum_addr_t);

hough_state_t state;

// Clear and scan counter, one bit wider to mark the end of the scan
logic [ADDR_BITS:0] cnt;

image_addr_t pix;
logic        img_vld;
logic        sweeping;
theta_idx_t  theta;
logic        pix_done;
vote_t       thr_q;

// Read address of the previous cycle, shared by vote and scan pipelines
accum_addr_t rd_addr_q;
logic        upd_vld;
logic        scan_vld;
logic        rd_issue;
theta_idx_t  scan_theta;

vote_t       left_max;
vote_t       right_max;
accum_addr_t left_addr;
accum_addr_t right_addr;
logic        left_hit;
logic        right_hit;

x_t          px;
y_t          py;
rho_t        rho_sum;
rho_t        rho_val;
rho_bin_t    bin;

function automatic rho_t lane_rho(accum_addr_t a);
    return rho_t'(a[BIN_BITS-1:0]) - rho_t'(`RHO_OFFSET);
endfunction

function automatic theta_deg_t lane_theta(accum_addr_t a);
    return theta_deg(a[ADDR_BITS-1:BIN_BITS]);
endfunction

assign image_rd_addr = pix;
assign px = pix[$bits(x_t)-1:0];
assign py = pix[$bits(image_addr_t)-1:$bits(x_t)];

// Rho rule, arithmetic shift rounds toward minus infinity
always_comb begin
    rho_sum = rho_t'(px) * rho_t'(cos_q(theta)) + rho_t'(py) * rho_t'(sin_q(theta));
    rho_val = rho_sum >>> 8;
    bin = rho_bin_t'(rho_val + `RHO_OFFSET);
end

assign accum_rd_addr = (state == SCAN) ? accum_addr_t'(cnt) : {theta, bin};
assign rd_issue = sweeping || ((state == SCAN) && !cnt[ADDR_BITS]);
assign scan_theta = rd_addr_q[ADDR_BITS-1:BIN_BITS];

// Pixel finished: last theta of a sweep, or a non-edge pixel
assign pix_done = (state == VOTE) &&
                  (sweeping ? (theta == theta_idx_t'(`NUM_THETAS - 1))
                            : (img_vld && !image_rd_data));

assign left_hit  = (left_max >= thr_q);
assign right_hit = (right_max >= thr_q);

always_ff @(posedge clock) begin
    if (reset) begin
        state       <= IDLE;
        busy        <= 1'b0;
        hough_done  <= 1'b0;
        cnt         <= '0;
        pix         <= '0;
        img_vld     <= 1'b0;
        sweeping    <= 1'b0;
        theta       <= '0;
        upd_vld     <= 1'b0;
        scan_vld    <= 1'b0;
        accum_wr_en <= 1'b0;
        left_valid  <= 1'b0;
        right_valid <= 1'b0;
    end else begin
        hough_done <= 1'b0;
        // Second RMW stage writes one cycle after the read data returns
        accum_wr_en <= upd_vld;
        upd_vld     <= sweeping;
        scan_vld    <= (state == SCAN) && !cnt[ADDR_BITS];
        case (state)
            IDLE: begin
                if (start) begin
                    state <= CLEAR;
                    busy  <= 1'b1;
                    cnt   <= '0;
                end
            end
            CLEAR: begin
                accum_wr_en <= 1'b1;
                cnt <= cnt + 1'b1;
                if (cnt == ACCUM_ENTRIES - 1) begin
                    state   <= VOTE;
                    pix     <= '0;
                    img_vld <= 1'b0;
                    theta   <= '0;
                end
            end
            VOTE: begin
                if (sweeping) begin
                    theta <= theta + 1'b1;
                    if (pix_done)
                        sweeping <= 1'b0;
                end else if (img_vld) begin
                    img_vld <= 1'b0;
                    if (image_rd_data)
                        sweeping <= 1'b1;
                end else begin
                    img_vld <= 1'b1;
                end
                if (pix_done) begin
                    if (pix == image_addr_t'(`IMG_PIXELS - 1)) begin
                        state <= SCAN;
                        cnt   <= '0;
                    end else begin
                        pix <= pix + 1'b1;
                    end
                end
            end
            SCAN: begin
                cnt <= cnt + 1'b1;
                // Last compare lands at the end of this cycle
                if (cnt == ACCUM_ENTRIES)
                    state <= REPORT;
            end
            REPORT: begin
                state       <= IDLE;
                busy        <= 1'b0;
                hough_done  <= 1'b1;
                left_valid  <= left_hit;
                right_valid <= right_hit;
            end
            default: state <= IDLE;
        endcase
    end
end

// Datapath registers
always_ff @(posedge clock) begin
    rd_addr_q <= accum_rd_addr;
    if (state == IDLE && start)
        thr_q <= threshold;
    if (state == CLEAR) begin
        accum_wr_addr <= accum_addr_t'(cnt);
        accum_wr_data <= '0;
    end else begin
        accum_wr_addr <= rd_addr_q;
        accum_wr_data <= (accum_rd_data == '1) ? accum_rd_data : accum_rd_data + 1'b1;
    end

    // Peak tracking, first entry of each half wins ties
    if (state == IDLE) begin
        left_max   <= '0;
        right_max  <= '0;
        left_addr  <= '0;
        right_addr <= accum_addr_t'(`HALF_THETAS * `RHO_BINS);
    end else if (scan_vld) begin
        if (scan_theta < theta_idx_t'(`HALF_THETAS)) begin
            if (accum_rd_data > left_max) begin
                left_max  <= accum_rd_data;
                left_addr <= rd_addr_q;
            end
        end else if (accum_rd_data > right_max) begin
            right_max  <= accum_rd_data;
            right_addr <= rd_addr_q;
        end
    end

    if (state == REPORT) begin
        left_rho    <= left_hit ? lane_rho(left_addr) : '0;
        left_theta  <= left_hit ? lane_theta(left_addr) : '0;
        right_rho   <= right_hit ? lane_rho(right_addr) : '0;
        right_theta <= right_hit ? lane_theta(right_addr) : '0;
    end
end

// Loader must hold the next frame until the engine is idle
assert property (@(posedge clock) disable iff (reset) start |-> !busy);

// Two updates in flight never collide with the read in progress
assert property (@(posedge clock) disable iff (reset)
    (accum_wr_en && rd_issue) |-> (accum_wr_addr != accum_rd_addr));

endmodule

/* source/hough_config.sv */
// Vote threshold register, locked while the Hough engine runs
`timescale 1ns/100ps
`include "hough_defs.svh"

module hough_config import hough_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   cfg_wr_en,
    input  vote_t  cfg_threshold,
    input  logic   busy,
    output vote_t  threshold
);

// Writes during a frame are dropped, not deferred
always_ff @(posedge clock) begin
    if (reset)
        threshold <= vote_t'(`DEFAULT_THRESHOLD);
    else if (cfg_wr_en && !busy)
        threshold <= cfg_threshold;
end

endmodule

/* source/hysteresis_loader.sv */
// Loader from the pixel FIFO into the edge-bit image BRAM with frame start pulse
`timescale 1ns/100ps
`include "hough_defs.svh"

module hysteresis_loader import image_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_empty,
    input  pixel_t      in_dout,
    output logic        in_rd_en,
    input  logic        busy,
    output logic        bram_wr_en,
    output image_addr_t bram_wr_addr,
    output logic        bram_wr_data,
    output logic        hough_start
);

image_addr_t rd_count;
logic        hold;
logic        last_read;

// Hold covers the gap between the last read of a frame and busy rising
assign in_rd_en  = !in_empty && !busy && !hold;
assign last_read = in_rd_en && (rd_count == image_addr_t'(`IMG_PIXELS - 1));

// Any nonzero strength counts as an edge
assign bram_wr_data = |in_dout[7:0];

always_ff @(posedge clock) begin
    if (reset) begin
        rd_count     <= '0;
        hold         <= 1'b0;
        bram_wr_en   <= 1'b0;
        bram_wr_addr <= '0;
        hough_start  <= 1'b0;
    end else begin
        // FIFO output is valid one cycle after the read
        bram_wr_en  <= in_rd_en;
        hough_start <= bram_wr_en && (bram_wr_addr == image_addr_t'(`IMG_PIXELS - 1));
        if (bram_wr_en)
            bram_wr_addr <= bram_wr_addr + 1'b1;
        if (in_rd_en)
            rd_count <= rd_count + 1'b1;
        if (last_read)
            hold <= 1'b1;
        else if (busy)
            hold <= 1'b0;
    end
end

// The engine owns the image BRAM from the start pulse until it releases the frame
assert property (@(posedge clock) disable iff (reset) (hough_start || busy) |-> !bram_wr_en);

endmodule

/* source/bram.sv */
// Simple dual-port RAM with one write port and a registered read port
`timescale 1ns/100ps

module bram #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 512
) (
    input  logic                       clock,
    input  logic                       wr_en,
    input  logic [$clog2(DEPTH)-1:0]   wr_addr,
    input  logic [DATA_WIDTH-1:0]      wr_data,
    input  logic [$clog2(DEPTH)-1:0]   rd_addr,
    output logic [DATA_WIDTH-1:0]      rd_data
);

logic [DATA_WIDTH-1:0] mem [DEPTH];

// Read returns old contents on a same-address write
always_ff @(posedge clock) begin
    if (wr_en)
        mem[wr_addr] <= wr_data;
    rd_data <= mem[rd_addr];
end

endmodule

/* source/fifo.sv */
// Synchronous pixel FIFO with registered output and full and empty flags
`timescale 1ns/100ps
`include "hough_defs.svh"

module fifo import image_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    wr_en,
    input  pixel_t  din,
    output logic    full,
    input  logic    rd_en,
    output pixel_t  dout,
    output logic    empty
);

localparam int ADDR_BITS = $clog2(`FIFO_DEPTH);

pixel_t mem [`FIFO_DEPTH];

// Extra pointer bit tells full from empty
logic [ADDR_BITS:0] wr_ptr;
logic [ADDR_BITS:0] rd_ptr;

assign empty = (wr_ptr == rd_ptr);
assign full  = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
               (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

always_ff @(posedge clock) begin
    if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
    end else begin
        if (wr_en && !full)
            wr_ptr <= wr_ptr + 1'b1;
        if (rd_en && !empty)
            rd_ptr <= rd_ptr + 1'b1;
    end
end

// Storage and output word
always_ff @(posedge clock) begin
    if (wr_en && !full)
        mem[wr_ptr[ADDR_BITS-1:0]] <= din;
    if (rd_en && !empty)
        dout <= mem[rd_ptr[ADDR_BITS-1:0]];
end

// Source and loader must both respect the flags
assert property (@(posedge clock) disable iff (reset) !(wr_en && full) && !(rd_en && empty));

endmodule

/* source/hough_pkg.sv */
// Theta, rho, vote and accumulator types, engine state enum and quantized trig functions
`include "hough_defs.svh"

package hough_pkg;

    typedef logic [$clog2(`NUM_THETAS)-1:0] theta_idx_t;
    typedef logic [8:0] theta_deg_t;
    typedef logic signed [15:0] rho_t;
    typedef logic [$clog2(`RHO_BINS)-1:0] rho_bin_t;

    // Votes saturate at 255
    typedef logic [7:0] vote_t;

    // Trig values scaled by 256
    typedef logic signed [11:0] trig_t;

    // Theta index in the upper bits, rho bin in the lower bits
    typedef logic [$clog2(`NUM_THETAS * `RHO_BINS)-1:0] accum_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        VOTE,
        SCAN,
        REPORT
    } hough_state_t;

    localparam int THETA_START_DEG = 20;
    localparam int THETA_STEP_DEG = 10;

    // round(256 * cos) and round(256 * sin) for 20, 30, ... 170 degrees
    localparam trig_t COS_TABLE [`NUM_THETAS] = '{
        241, 222, 196, 165, 128, 88, 44, 0,
        -44, -88, -128, -165, -196, -222, -241, -252
    };
    localparam trig_t SIN_TABLE [`NUM_THETAS] = '{
        88, 128, 165, 196, 222, 241, 252, 256,
        252, 241, 222, 196, 165, 128, 88, 44
    };

    function automatic trig_t cos_q(theta_idx_t idx);
        return COS_TABLE[idx];
    endfunction

    function automatic trig_t sin_q(theta_idx_t idx);
        return SIN_TABLE[idx];
    endfunction

    function automatic theta_deg_t theta_deg(theta_idx_t idx);
        return theta_deg_t'(THETA_START_DEG + THETA_STEP_DEG * idx);
    endfunction

endpackage

/* source/image_pkg.sv */
// Pixel, column, row and image address types
`include "hough_defs.svh"

package image_pkg;

    // Hysteresis output pixel, the low byte carries the edge strength
    typedef logic [23:0] pixel_t;

    // Pixel coordinates
    typedef logic [$clog2(`IMG_WIDTH)-1:0] x_t;
    typedef logic [$clog2(`IMG_HEIGHT)-1:0] y_t;

    // Row times width plus column, so the row sits in the upper bits
    typedef logic [$clog2(`IMG_PIXELS)-1:0] image_addr_t;

endpackage

/* source/hough_defs.svh */
// Image geometry, theta sweep, rho binning, threshold and FIFO depth macros
`ifndef HOUGH_DEFS_SVH
`define HOUGH_DEFS_SVH

// Full frame, no cropping
`define IMG_WIDTH   32
`define IMG_HEIGHT  16
`define IMG_PIXELS  (`IMG_WIDTH * `IMG_HEIGHT)

// 20 to 170 degrees in steps of 10, split into two lane halves
`define NUM_THETAS  16
`define HALF_THETAS (`NUM_THETAS / 2)

// Rho bins cover -64..63, signed rho plus offset gives the bin
`define RHO_BINS    128
`define RHO_OFFSET  (`RHO_BINS / 2)

// Minimum peak votes for a valid lane
`define DEFAULT_THRESHOLD 12

// Input pixel buffer
`define FIFO_DEPTH  8

`endif
